// File: files.f
common/mem_pkg.sv
common/lsu_pkg.sv
lsu/lsu_ctrl.sv
logic/dtcm_arbiter.sv
logic/dtcm_ram.sv
logic/lsu_subsys.sv
tb/tb_lsu_subsys.sv

// File: Bender.yml
package:
  name: lsu_subsys

sources:
  - common/mem_pkg.sv
  - common/lsu_pkg.sv
  - lsu/lsu_ctrl.sv
  - logic/dtcm_arbiter.sv
  - logic/dtcm_ram.sv
  - logic/lsu_subsys.sv
  - target: test
    files:
      - tb/tb_lsu_subsys.sv

// File: tb/tb_lsu_subsys.sv
//========================================
// LSU subsystem testbench
// Drives the AGU, write-back and DMA ports
// and checks results against a byte-array
// reference model of the DTCM
//========================================
`timescale 1ns/1ps

module tb_lsu_subsys;

    localparam int dtcm_depth = 256;
    localparam int mem_bytes  = dtcm_depth * 4;
    localparam int wait_limit = 64;
    localparam int burst_len  = 16;

    logic               clk;
    logic               reset;
    logic               agu_cmd_valid;
    logic               agu_cmd_ready;
    lsu_pkg::agu_cmd_t  agu_cmd;
    logic               lsu_o_valid;
    logic               lsu_o_ready;
    lsu_pkg::wbck_t     lsu_o_wbck;
    logic               dma_cmd_valid;
    logic               dma_cmd_ready;
    mem_pkg::dtcm_cmd_t dma_cmd;
    logic               dma_rsp_valid;
    lsu_pkg::xlen_t     dma_rsp_rdata;

    int          errors       = 0;
    int          err_at_start = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    int          cyc          = 0;
    int          tie_cnt      = 0;
    int          lsu_done     = 0;
    int          dma_done     = 0;
    logic [31:0] rng_state    = 32'd6;
    logic [7:0]  ref_mem [mem_bytes];

    // Arbitration monitor, 1 means the DMA port won
    logic lsu_req;
    logic lsu_acc;
    logic dma_acc;
    logic last_win;
    logic have_last;

    lsu_subsys #(
        .dtcm_depth (dtcm_depth)
    ) u_lsu_subsys (
        .clk           (clk),
        .reset         (reset),
        .agu_cmd_valid (agu_cmd_valid),
        .agu_cmd_ready (agu_cmd_ready),
        .agu_cmd       (agu_cmd),
        .lsu_o_valid   (lsu_o_valid),
        .lsu_o_ready   (lsu_o_ready),
        .lsu_o_wbck    (lsu_o_wbck),
        .dma_cmd_valid (dma_cmd_valid),
        .dma_cmd_ready (dma_cmd_ready),
        .dma_cmd       (dma_cmd),
        .dma_rsp_valid (dma_rsp_valid),
        .dma_rsp_rdata (dma_rsp_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    assign lsu_req = u_lsu_subsys.lsu_cmd_valid;
    assign lsu_acc = lsu_req && u_lsu_subsys.lsu_cmd_ready;
    assign dma_acc = dma_cmd_valid && dma_cmd_ready;

    always @(posedge clk) begin
        if (reset) begin
            have_last <= 1'b0;
            last_win  <= 1'b0;
        end else if (lsu_acc || dma_acc) begin
            have_last <= 1'b1;
            last_win  <= dma_acc;
            if (lsu_req && dma_cmd_valid) begin
                tie_cnt <= tie_cnt + 1;
            end
        end
    end

    // Completed accesses as seen on the DUT ports
    always @(posedge clk) begin
        if (lsu_o_valid && lsu_o_ready) lsu_done <= lsu_done + 1;
        if (dma_rsp_valid) dma_done <= dma_done + 1;
    end

    //========================================
    // Protocol assertions
    //========================================

    a_alternate: assert property (@(posedge clk) disable iff (reset)
        lsu_req && dma_cmd_valid && (lsu_acc || dma_acc) && have_last |-> (dma_acc != last_win))
    else begin
        $display("** Error: dma_acc 0x%h repeats last winner 0x%h on a tie",
                 $sampled(dma_acc), $sampled(last_win));
        errors++;
    end

    a_wbck_hold: assert property (@(posedge clk) disable iff (reset)
        lsu_o_valid && !lsu_o_ready |=> lsu_o_valid && $stable(lsu_o_wbck))
    else begin
        $display("** Error: lsu_o_wbck 0x%h not held under back-pressure",
                 $sampled(lsu_o_wbck));
        errors++;
    end

    a_busy_during_wbck: assert property (@(posedge clk) disable iff (reset)
        lsu_o_valid |-> !agu_cmd_ready)
    else begin
        $display("** Error: agu_cmd_ready 0x%h during write-back, expected 0x0",
                 $sampled(agu_cmd_ready));
        errors++;
    end

    a_ready_after_wbck: assert property (@(posedge clk) disable iff (reset)
        lsu_o_valid && lsu_o_ready |=> agu_cmd_ready)
    else begin
        $display("** Error: agu_cmd_ready 0x%h after write-back, expected 0x1",
                 $sampled(agu_cmd_ready));
        errors++;
    end

    //========================================
    // Helpers
    //========================================

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic int byte_index(input logic [31:0] addr);
        return int'(addr % mem_bytes);
    endfunction

    // Expected load result built from model bytes, little endian
    function automatic logic [31:0] ref_load(input logic [31:0] addr,
                                             input lsu_pkg::lsu_size_e size);
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        logic [7:0] b3;
        b0 = ref_mem[byte_index(addr)];
        b1 = ref_mem[byte_index(addr + 1)];
        b2 = ref_mem[byte_index(addr + 2)];
        b3 = ref_mem[byte_index(addr + 3)];
        case (size)
            lsu_pkg::lsu_byte:   return {{24{b0[7]}}, b0};
            lsu_pkg::lsu_byte_u: return {24'h0, b0};
            lsu_pkg::lsu_half:   return {{16{b1[7]}}, b1, b0};
            lsu_pkg::lsu_half_u: return {16'h0, b1, b0};
            default:             return {b3, b2, b1, b0};
        endcase
    endfunction

    task automatic model_agu_store(input logic [31:0] addr, input logic [31:0] wdata,
                                   input lsu_pkg::lsu_size_e size);
        int n;
        n = 1;
        if (size == lsu_pkg::lsu_word) begin
            n = 4;
        end else if (size == lsu_pkg::lsu_half || size == lsu_pkg::lsu_half_u) begin
            n = 2;
        end
        for (int i = 0; i < n; i++) begin
            ref_mem[byte_index(addr + i)] = wdata[8*i +: 8];
        end
    endtask

    task automatic model_dma_store(input logic [31:0] addr, input logic [31:0] wdata,
                                   input logic [3:0] wmask);
        for (int b = 0; b < 4; b++) begin
            if (wmask[b]) begin
                ref_mem[byte_index({addr[31:2], 2'(b)})] = wdata[8*b +: 8];
            end
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else begin
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout: %s", what);
        $display("=== FAIL ===");
        $finish;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == err_at_start) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                     errors - err_at_start);
        end
        err_at_start = errors;
    endtask

    //========================================
    // Port drivers
    //========================================

    // One AGU command through to its write-back record
    task automatic agu_access(input logic rd, input logic [31:0] addr,
                              input logic [31:0] wdata, input lsu_pkg::lsu_size_e size,
                              input lsu_pkg::itag_t itag, input bit check_lat,
                              output lsu_pkg::wbck_t wb);
        int t;
        int hs_cyc;
        @(negedge clk);
        agu_cmd_valid = 1'b1;
        agu_cmd.read  = rd;
        agu_cmd.addr  = addr;
        agu_cmd.wdata = wdata;
        agu_cmd.size  = size;
        agu_cmd.itag  = itag;
        t = 0;
        while (!agu_cmd_ready) begin
            @(negedge clk);
            t++;
            if (t > wait_limit) abort_on_timeout("AGU command never accepted");
        end
        hs_cyc        = cyc;
        @(negedge clk);
        agu_cmd_valid = 1'b0;
        if (!rd) model_agu_store(addr, wdata, size);
        t = 0;
        while (!lsu_o_valid) begin
            @(negedge clk);
            t++;
            if (t > wait_limit) abort_on_timeout("no write-back for an AGU command");
        end
        wb = lsu_o_wbck;
        if (check_lat) check_value("lsu_o_valid latency", cyc - hs_cyc, 3);
        check_value("lsu_o_wbck.itag", wb.itag, itag);
        check_value("lsu_o_wbck.rd_wen", wb.rd_wen, rd);
    endtask

    task automatic dma_access(input logic rd, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [3:0] wmask,
                              output logic [31:0] rdata);
        int t;
        @(negedge clk);
        dma_cmd_valid = 1'b1;
        dma_cmd.read  = rd;
        dma_cmd.addr  = addr;
        dma_cmd.wdata = wdata;
        dma_cmd.wmask = rd ? 4'h0 : wmask;
        // Accepted on the first rising edge that sees ready high
        t = 0;
        @(posedge clk);
        while (!dma_cmd_ready) begin
            @(posedge clk);
            t++;
            if (t > wait_limit) abort_on_timeout("DMA command never accepted");
        end
        @(negedge clk);
        dma_cmd_valid = 1'b0;
        if (!rd) model_dma_store(addr, wdata, wmask);
        t = 0;
        while (!dma_rsp_valid) begin
            @(negedge clk);
            t++;
            if (t > wait_limit) abort_on_timeout("no DMA response");
        end
        rdata = dma_rsp_rdata;
    endtask

    // Random upper bits exercise the word-index wrap
    task automatic lsu_stream(input logic rd, input logic [31:0] region);
        lsu_pkg::wbck_t wb;
        logic [31:0]    addr;
        for (int i = 0; i < burst_len; i++) begin
            addr       = next_rand();
            addr[11:0] = 12'(region + 4 * i);
            agu_access(rd, addr, next_rand(), lsu_pkg::lsu_word, 1'(i), 1'b0, wb);
            if (rd) check_value("lsu_o_wbck.wdat", wb.wdat, ref_load(addr, lsu_pkg::lsu_word));
        end
    endtask

    task automatic dma_stream(input logic rd, input logic [31:0] region);
        logic [31:0] addr;
        logic [31:0] rdata;
        for (int i = 0; i < burst_len; i++) begin
            addr       = next_rand();
            addr[11:0] = 12'(region + 4 * i);
            dma_access(rd, addr, next_rand(), 4'hf, rdata);
            if (rd) check_value("dma_rsp_rdata", rdata, ref_load(addr, lsu_pkg::lsu_word));
        end
    endtask

    //========================================
    // Tests
    //========================================

    initial begin
        lsu_pkg::wbck_t wb;
        lsu_pkg::wbck_t held;
        logic [31:0]    base;
        logic [31:0]    data;
        reset         = 1'b1;
        agu_cmd_valid = 1'b0;
        agu_cmd       = '0;
        lsu_o_ready   = 1'b1;
        dma_cmd_valid = 1'b0;
        dma_cmd       = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Reset values and a word round trip
        check_value("lsu_o_valid", lsu_o_valid, 0);
        check_value("dma_rsp_valid", dma_rsp_valid, 0);
        check_value("agu_cmd_ready", agu_cmd_ready, 1);
        base = next_rand() & 32'hffff_fffc;
        data = next_rand();
        agu_access(1'b0, base, data, lsu_pkg::lsu_word, 1'b0, 1'b1, wb);
        agu_access(1'b1, base, 32'h0, lsu_pkg::lsu_word, 1'b1, 1'b1, wb);
        check_value("lsu_o_wbck.wdat", wb.wdat, data);
        finish_test("word store and load");

        // Sub-word stores at every offset, then every load size
        base = next_rand() & 32'hffff_fffc;
        for (int off = 0; off < 4; off++) begin
            agu_access(1'b0, base + off, next_rand(), lsu_pkg::lsu_byte, 1'b0, 1'b1, wb);
        end
        for (int off = 0; off < 4; off += 2) begin
            agu_access(1'b0, base + 4 + off, next_rand(), lsu_pkg::lsu_half, 1'b1, 1'b1, wb);
        end
        for (int off = 0; off < 8; off++) begin
            agu_access(1'b1, base + off, 32'h0, lsu_pkg::lsu_byte, 1'b0, 1'b1, wb);
            check_value("lsu_o_wbck.wdat", wb.wdat, ref_load(base + off, lsu_pkg::lsu_byte));
            agu_access(1'b1, base + off, 32'h0, lsu_pkg::lsu_byte_u, 1'b1, 1'b1, wb);
            check_value("lsu_o_wbck.wdat", wb.wdat, ref_load(base + off, lsu_pkg::lsu_byte_u));
        end
        for (int off = 0; off < 8; off += 2) begin
            agu_access(1'b1, base + off, 32'h0, lsu_pkg::lsu_half, 1'b0, 1'b1, wb);
            check_value("lsu_o_wbck.wdat", wb.wdat, ref_load(base + off, lsu_pkg::lsu_half));
            agu_access(1'b1, base + off, 32'h0, lsu_pkg::lsu_half_u, 1'b1, 1'b1, wb);
            check_value("lsu_o_wbck.wdat", wb.wdat, ref_load(base + off, lsu_pkg::lsu_half_u));
        end
        finish_test("sub-word stores and extended loads");

        // Tags follow their commands, latency fixed with DMA idle
        for (int i = 0; i < 6; i++) begin
            agu_access(1'b1, base + 4 * (i % 2), 32'h0, lsu_pkg::lsu_word, 1'((i * 3) >> 1),
                       1'b1, wb);
        end
        finish_test("itag and latency");

        // Back-pressure on the write-back port
        @(negedge clk);
        lsu_o_ready = 1'b0;
        agu_access(1'b1, base, 32'h0, lsu_pkg::lsu_word, 1'b1, 1'b1, held);
        check_value("lsu_o_wbck.wdat", held.wdat, ref_load(base, lsu_pkg::lsu_word));
        repeat (5) begin
            @(negedge clk);
            check_value("lsu_o_valid", lsu_o_valid, 1);
            check_value("agu_cmd_ready", agu_cmd_ready, 0);
        end
        lsu_o_ready = 1'b1;
        @(negedge clk);
        check_value("agu_cmd_ready", agu_cmd_ready, 1);
        finish_test("write-back back-pressure");

        // Both peers at once, each writes its own region then reads the other's
        lsu_done = 0;
        dma_done = 0;
        tie_cnt  = 0;
        fork
            lsu_stream(1'b0, 32'h100);
            dma_stream(1'b0, 32'h200);
        join
        fork
            lsu_stream(1'b1, 32'h200);
            dma_stream(1'b1, 32'h100);
        join
        // Let the last write-back and response be counted
        @(negedge clk);
        check_value("lsu accesses done", lsu_done, 2 * burst_len);
        check_value("dma accesses done", dma_done, 2 * burst_len);
        if (tie_cnt == 0) begin
            $display("The LSU and DMA ports never requested in the same cycle");
            errors++;
        end
        finish_test("concurrent LSU and DMA traffic");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: logic/lsu_subsys.sv
//========================================
// LSU subsystem top level
// LSU control, DTCM arbiter and DTCM with
// AGU, write-back and DMA ports
//========================================
`timescale 1ns/1ps

module lsu_subsys #(
    parameter int dtcm_depth = 256
) (
    input  logic                clk,
    input  logic                reset,
    // AGU
    input  logic                agu_cmd_valid,
    output logic                agu_cmd_ready,
    input  lsu_pkg::agu_cmd_t   agu_cmd,
    // Write-back
    output logic                lsu_o_valid,
    input  logic                lsu_o_ready,
    output lsu_pkg::wbck_t      lsu_o_wbck,
    // DMA
    input  logic                dma_cmd_valid,
    output logic                dma_cmd_ready,
    input  mem_pkg::dtcm_cmd_t  dma_cmd,
    output logic                dma_rsp_valid,
    output lsu_pkg::xlen_t      dma_rsp_rdata
);

    // LSU to arbiter
    logic               lsu_cmd_valid;
    logic               lsu_cmd_ready;
    mem_pkg::dtcm_cmd_t lsu_cmd;
    logic               lsu_rsp_valid;
    lsu_pkg::xlen_t     lsu_rsp_rdata;

    // Arbiter to RAM
    logic               mem_cmd_valid;
    logic               mem_cmd_ready;
    mem_pkg::dtcm_cmd_t mem_cmd;
    logic               mem_rsp_valid;
    lsu_pkg::xlen_t     mem_rsp_rdata;

    lsu_ctrl u_lsu_ctrl (
        .clk            (clk),
        .reset          (reset),
        .agu_cmd_valid  (agu_cmd_valid),
        .agu_cmd_ready  (agu_cmd_ready),
        .agu_cmd        (agu_cmd),
        .lsu_o_valid    (lsu_o_valid),
        .lsu_o_ready    (lsu_o_ready),
        .lsu_o_wbck     (lsu_o_wbck),
        .dtcm_cmd_valid (lsu_cmd_valid),
        .dtcm_cmd_ready (lsu_cmd_ready),
        .dtcm_cmd       (lsu_cmd),
        .dtcm_rsp_valid (lsu_rsp_valid),
        .dtcm_rsp_rdata (lsu_rsp_rdata)
    );

    dtcm_arbiter u_dtcm_arbiter (
        .clk           (clk),
        .reset         (reset),
        .lsu_cmd_valid (lsu_cmd_valid),
        .lsu_cmd_ready (lsu_cmd_ready),
        .lsu_cmd       (lsu_cmd),
        .lsu_rsp_valid (lsu_rsp_valid),
        .lsu_rsp_rdata (lsu_rsp_rdata),
        .dma_cmd_valid (dma_cmd_valid),
        .dma_cmd_ready (dma_cmd_ready),
        .dma_cmd       (dma_cmd),
        .dma_rsp_valid (dma_rsp_valid),
        .dma_rsp_rdata (dma_rsp_rdata),
        .mem_cmd_valid (mem_cmd_valid),
        .mem_cmd_ready (mem_cmd_ready),
        .mem_cmd       (mem_cmd),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_rdata (mem_rsp_rdata)
    );

    dtcm_ram #(
        .dtcm_depth (dtcm_depth)
    ) u_dtcm_ram (
        .clk           (clk),
        .reset         (reset),
        .mem_cmd_valid (mem_cmd_valid),
        .mem_cmd_ready (mem_cmd_ready),
        .mem_cmd       (mem_cmd),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_rdata (mem_rsp_rdata)
    );

endmodule

// File: logic/dtcm_ram.sv
//========================================
// DTCM single-port data memory
// Byte write enables, response one cycle
// after each accepted command
//========================================
`timescale 1ns/1ps

module dtcm_ram #(
    parameter int dtcm_depth = 256
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                mem_cmd_valid,
    output logic                mem_cmd_ready,
    input  mem_pkg::dtcm_cmd_t  mem_cmd,
    output logic                mem_rsp_valid,
    output lsu_pkg::xlen_t      mem_rsp_rdata
);

    localparam int idx_w = $clog2(dtcm_depth);

    lsu_pkg::xlen_t   mem [dtcm_depth];
    logic [idx_w-1:0] word_idx;
    logic             accept;
    logic             rsp_valid_q;
    lsu_pkg::xlen_t   rdata_q;

    // Word index wraps at the array depth
    assign word_idx      = idx_w'((mem_cmd.addr >> 2) % dtcm_depth);
    assign mem_cmd_ready = !rsp_valid_q;
    assign accept        = mem_cmd_valid && mem_cmd_ready;

    always_ff @(posedge clk) begin
        if (accept) begin
            if (mem_cmd.read) begin
                rdata_q <= mem[word_idx];
            end else begin
                for (int b = 0; b < mem_pkg::dtcm_lanes; b++) begin
                    if (mem_cmd.wmask[b]) begin
                        mem[word_idx][b*8 +: 8] <= mem_cmd.wdata[b*8 +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= accept;
        end
    end

    assign mem_rsp_valid = rsp_valid_q;
    assign mem_rsp_rdata = rdata_q;

    // One-cycle pulse after each accepted command
    a_rsp_pulse: assert property (@(posedge clk) disable iff (reset)
        accept |=> mem_rsp_valid ##1 !mem_rsp_valid);

endmodule

// File: logic/dtcm_arbiter.sv
//========================================
// DTCM round-robin arbiter
// Shares one DTCM port between the LSU and
// DMA peers, one access in flight
//========================================
`timescale 1ns/1ps

module dtcm_arbiter (
    input  logic                clk,
    input  logic                reset,
    // Port 0, LSU
    input  logic                lsu_cmd_valid,
    output logic                lsu_cmd_ready,
    input  mem_pkg::dtcm_cmd_t  lsu_cmd,
    output logic                lsu_rsp_valid,
    output lsu_pkg::xlen_t      lsu_rsp_rdata,
    // Port 1, DMA
    input  logic                dma_cmd_valid,
    output logic                dma_cmd_ready,
    input  mem_pkg::dtcm_cmd_t  dma_cmd,
    output logic                dma_rsp_valid,
    output lsu_pkg::xlen_t      dma_rsp_rdata,
    // Memory side
    output logic                mem_cmd_valid,
    input  logic                mem_cmd_ready,
    output mem_pkg::dtcm_cmd_t  mem_cmd,
    input  logic                mem_rsp_valid,
    input  lsu_pkg::xlen_t      mem_rsp_rdata
);

    // Owner and last-winner bits, 1 means the DMA port
    logic busy_q;
    logic owner_q;
    logic last_q;
    logic gnt_lsu;
    logic gnt_dma;
    logic mem_hs;

    //========================================
    // Grant
    //========================================

    // On a tie the port that did not win last goes first
    assign gnt_lsu = !busy_q && lsu_cmd_valid && (!dma_cmd_valid || last_q);
    assign gnt_dma = !busy_q && dma_cmd_valid && (!lsu_cmd_valid || !last_q);

    assign mem_cmd_valid = gnt_lsu || gnt_dma;
    assign mem_cmd       = gnt_dma ? dma_cmd : lsu_cmd;
    assign mem_hs        = mem_cmd_valid && mem_cmd_ready;

    assign lsu_cmd_ready = gnt_lsu && mem_cmd_ready;
    assign dma_cmd_ready = gnt_dma && mem_cmd_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q  <= 1'b0;
            owner_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            if (mem_hs) begin
                busy_q  <= 1'b1;
                owner_q <= gnt_dma;
                last_q  <= gnt_dma;
            end else if (mem_rsp_valid) begin
                busy_q <= 1'b0;
            end
        end
    end

    //========================================
    // Response steering
    //========================================

    assign lsu_rsp_valid = mem_rsp_valid && busy_q && !owner_q;
    assign dma_rsp_valid = mem_rsp_valid && busy_q && owner_q;
    assign lsu_rsp_rdata = mem_rsp_rdata;
    assign dma_rsp_rdata = mem_rsp_rdata;

    //========================================
    // Assertions
    //========================================

    a_single_grant: assert property (@(posedge clk) disable iff (reset)
        $onehot0({lsu_cmd_ready, dma_cmd_ready}));

    // Nothing new reaches the RAM until the current response is back
    a_no_issue_busy: assert property (@(posedge clk) disable iff (reset)
        mem_hs |=> !mem_cmd_valid until_with mem_rsp_valid);

endmodule

// File: lsu/lsu_ctrl.sv
//========================================
// Load/store control unit
// Issues one AGU command at a time to the
// DTCM, aligns and extends load data and
// returns it on the write-back port
//========================================
`timescale 1ns/1ps

module lsu_ctrl (
    input  logic                clk,
    input  logic                reset,
    // AGU command
    input  logic                agu_cmd_valid,
    output logic                agu_cmd_ready,
    input  lsu_pkg::agu_cmd_t   agu_cmd,
    // Long-pipe write-back
    output logic                lsu_o_valid,
    input  logic                lsu_o_ready,
    output lsu_pkg::wbck_t      lsu_o_wbck,
    // DTCM port
    output logic                dtcm_cmd_valid,
    input  logic                dtcm_cmd_ready,
    output mem_pkg::dtcm_cmd_t  dtcm_cmd,
    input  logic                dtcm_rsp_valid,
    input  lsu_pkg::xlen_t      dtcm_rsp_rdata
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait_rsp,
        st_wbck
    } state_e;

    state_e             state_q;
    logic               cmd_pend_q;
    lsu_pkg::agu_cmd_t  cmd_q;
    lsu_pkg::wbck_t     wbck_q;
    logic               agu_hs;
    logic               dtcm_hs;
    logic               rsp_take;
    logic [1:0]         byte_off;
    mem_pkg::wmask_t    wmask;
    lsu_pkg::xlen_t     rdata_algn;
    lsu_pkg::xlen_t     load_data;

    //========================================
    // Handshakes
    //========================================

    // Only one access in flight, so accept only when fully idle
    assign agu_cmd_ready  = (state_q == st_idle);
    assign agu_hs         = agu_cmd_valid && agu_cmd_ready;
    assign dtcm_cmd_valid = (state_q == st_wait_rsp) && cmd_pend_q;
    assign dtcm_hs        = dtcm_cmd_valid && dtcm_cmd_ready;
    assign rsp_take       = (state_q == st_wait_rsp) && !cmd_pend_q && dtcm_rsp_valid;

    //========================================
    // Store lane placement
    //========================================

    assign byte_off = cmd_q.addr[1:0];

    always_comb begin
        case (cmd_q.size)
            lsu_pkg::lsu_byte, lsu_pkg::lsu_byte_u: wmask = 4'b0001 << byte_off;
            lsu_pkg::lsu_half, lsu_pkg::lsu_half_u: wmask = 4'b0011 << byte_off;
            default:                                wmask = 4'b1111;
        endcase
    end

    always_comb begin
        dtcm_cmd.read  = cmd_q.read;
        dtcm_cmd.addr  = cmd_q.addr;
        dtcm_cmd.wdata = cmd_q.wdata << {byte_off, 3'b000};
        // Loads write nothing
        dtcm_cmd.wmask = cmd_q.read ? '0 : wmask;
    end

    //========================================
    // Load alignment and extension
    //========================================

    assign rdata_algn = dtcm_rsp_rdata >> {byte_off, 3'b000};

    always_comb begin
        case (cmd_q.size)
            lsu_pkg::lsu_byte:
                load_data = {{(lsu_pkg::xlen-8){rdata_algn[7]}}, rdata_algn[7:0]};
            lsu_pkg::lsu_byte_u:
                load_data = {{(lsu_pkg::xlen-8){1'b0}}, rdata_algn[7:0]};
            lsu_pkg::lsu_half:
                load_data = {{(lsu_pkg::xlen-16){rdata_algn[15]}}, rdata_algn[15:0]};
            lsu_pkg::lsu_half_u:
                load_data = {{(lsu_pkg::xlen-16){1'b0}}, rdata_algn[15:0]};
            default:
                load_data = rdata_algn;
        endcase
    end

    //========================================
    // Control FSM
    //========================================

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q    <= st_idle;
            cmd_pend_q <= 1'b0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (agu_hs) begin
                        state_q    <= st_wait_rsp;
                        cmd_pend_q <= 1'b1;
                    end
                end
                st_wait_rsp: begin
                    if (dtcm_hs) begin
                        cmd_pend_q <= 1'b0;
                    end
                    if (rsp_take) begin
                        state_q <= st_wbck;
                    end
                end
                st_wbck: begin
                    // Hold the record until the consumer takes it
                    if (lsu_o_ready) begin
                        state_q <= st_idle;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (agu_hs) begin
            cmd_q <= agu_cmd;
        end
        if (rsp_take) begin
            wbck_q.wdat   <= cmd_q.read ? load_data : '0;
            wbck_q.itag   <= cmd_q.itag;
            wbck_q.rd_wen <= cmd_q.read;
        end
    end

    assign lsu_o_valid = (state_q == st_wbck);
    assign lsu_o_wbck  = wbck_q;

    //========================================
    // Assertions
    //========================================

    // No second AGU command until the write-back has been taken
    a_one_outstanding: assert property (@(posedge clk) disable iff (reset)
        agu_hs |=> !agu_cmd_ready until_with (lsu_o_valid && lsu_o_ready));

    // AGU delivers naturally aligned addresses
    a_half_aligned: assert property (@(posedge clk) disable iff (reset)
        agu_hs && (agu_cmd.size inside {lsu_pkg::lsu_half, lsu_pkg::lsu_half_u})
        |-> !agu_cmd.addr[0]);

    a_word_aligned: assert property (@(posedge clk) disable iff (reset)
        agu_hs && (agu_cmd.size == lsu_pkg::lsu_word) |-> (agu_cmd.addr[1:0] == 2'b00));

endmodule

// File: common/lsu_pkg.sv
//========================================
// Load/store unit core-side types
// Data word, instruction tag, access size,
// AGU command and write-back record
//========================================

package lsu_pkg;

    localparam int xlen = 32;

    // Two-entry tracking table needs a 1-bit tag
    localparam int itag_w = 1;

    typedef logic [xlen-1:0]   xlen_t;
    typedef logic [itag_w-1:0] itag_t;

    // Same encoding as the RISC-V load funct3 field
    typedef enum logic [2:0] {
        lsu_byte   = 3'b000,
        lsu_half   = 3'b001,
        lsu_word   = 3'b010,
        lsu_byte_u = 3'b100,
        lsu_half_u = 3'b101
    } lsu_size_e;

    //========================================
    // Records
    //========================================

    // Command from the address-generation unit
    typedef struct packed {
        logic                read;
        mem_pkg::dtcm_addr_t addr;
        xlen_t               wdata;
        lsu_size_e           size;
        itag_t               itag;
    } agu_cmd_t;

    // Long-pipe write-back, rd_wen set for loads only
    typedef struct packed {
        xlen_t wdat;
        itag_t itag;
        logic  rd_wen;
    } wbck_t;

endpackage

// File: common/mem_pkg.sv
//========================================
// DTCM memory-side types
// Byte address, byte-lane mask and the
// command record shared by the arbiter,
// the RAM and the LSU
//========================================

package mem_pkg;

    // Byte address and data width seen by the DTCM
    localparam int dtcm_addr_w = 32;
    localparam int dtcm_data_w = 32;

    // One mask bit per byte lane
    localparam int dtcm_lanes = dtcm_data_w / 8;

    typedef logic [dtcm_addr_w-1:0] dtcm_addr_t;
    typedef logic [dtcm_lanes-1:0]  wmask_t;

    //========================================
    // Command record
    //========================================

    // Read high for loads, wmask only meaningful on writes
    typedef struct packed {
        logic                   read;
        dtcm_addr_t             addr;
        logic [dtcm_data_w-1:0] wdata;
        wmask_t                 wmask;
    } dtcm_cmd_t;

endpackage
